/* hw/aluCtrlIf.sv */
`timescale 1ns/1ps
`default_nettype none

interface aluCtrlIf
	import cpuIsaPkg::*;
	import aluCtrlPkg::*;
();

	logic                 valid;                // Control word present
	aluOpE                op;
	regSeqE               regSeq;
	logic [regAddrW-1:0]  addrA;                // Already remapped for Acc modes
	logic [regAddrW-1:0]  addrB;
	srcBE                 srcB;
	logic [immWidth-1:0]  imm;                  // Raw low byte of the word
	logic                 ccLoad;               // Flags update on retire
	logic                 illegal;
	logic                 stall;                // From execute, hold word

	modport decode  (output valid, op, regSeq, addrA, addrB, srcB, imm, ccLoad, illegal,
	                 input  stall);
	modport execute (input  valid, op, regSeq, addrA, addrB, srcB, imm, ccLoad, illegal,
	                 output stall);

endinterface

`default_nettype wire

/* hw/aluCtrlPkg.sv */
`default_nettype none

package aluCtrlPkg;

	// ========================================================================
	// Operand B source select
	// ========================================================================
	typedef enum logic [1:0] {
		REG_B = 2'd0,                           // Register file port B
		IMM4  = 2'd1,                           // Zero-extended 4-bit value
		IMM8U = 2'd2,                           // Zero-extended 8-bit value
		IMM8S = 2'd3                            // Sign-extended 8-bit value
	} srcBE;

	// ========================================================================
	// Register access sequence
	// ========================================================================
	typedef enum logic [1:0] {
		READ_ONLY = 2'd0,                       // CMP, BIT: no write-back
		LOAD_A    = 2'd1,                       // MOV: A written, not read
		UPDATE_A  = 2'd2                        // Read-modify-write of A
	} regSeqE;

	// ========================================================================
	// Condition flags
	// ========================================================================
	typedef struct packed {
		logic z;                                // Zero
		logic n;                                // Negative
		logic c;                                // Carry or borrow
		logic v;                                // Signed overflow
	} flagsT;

endpackage

`default_nettype wire

/* hw/aluExecute.sv */
`timescale 1ns/1ps
`default_nettype none

module aluExecute
	import cpuIsaPkg::*;
	import aluCtrlPkg::*;
#(
	parameter int dataWidth = 16
) (
	input  wire         CLK,
	input  wire         rstN,
	aluCtrlIf.execute   ctrl,
	wbIf.execute        wb
);

	localparam int msb = dataWidth - 1;
	localparam int shW = $clog2(dataWidth);

	logic [dataWidth-1:0] opA;
	logic [dataWidth-1:0] opB;
	logic [dataWidth-1:0] res;
	logic [dataWidth:0]   wide;                   // Result plus carry bit
	logic [shW-1:0]       shAmt;
	flagsT                fl;

	assign wb.rdAddrA = ctrl.addrA;
	assign wb.rdAddrB = ctrl.addrB;
	assign ctrl.stall = wb.stall;                 // Hold decode while record waits

	// ========================================================================
	// Operand select and ALU
	// ========================================================================
	always_comb begin
		opA = wb.rdDataA;
		case (ctrl.srcB)
			IMM4:    opB = dataWidth'(ctrl.imm[imm4Width-1:0]);
			IMM8U:   opB = dataWidth'(ctrl.imm);
			IMM8S:   opB = {{(dataWidth - immWidth){ctrl.imm[immWidth-1]}}, ctrl.imm};
			default: opB = wb.rdDataB;
		endcase
		shAmt = opB[shW-1:0];                     // Shift count from B

		wide = '0;
		fl   = '0;                                 // C, V cleared unless set below
		case (ctrl.op)
			MOV: wide = {1'b0, opB};
			ADD, ADC: begin
				wide = {1'b0, opA} + {1'b0, opB}
				     + ((ctrl.op == ADC) ? (dataWidth + 1)'(wb.carryIn) : '0);
				fl.c = wide[dataWidth];               // Carry out
				fl.v = (opA[msb] == opB[msb]) && (wide[msb] != opA[msb]);
			end
			SUB, SBC, CMP: begin
				wide = {1'b0, opA} - {1'b0, opB}
				     - ((ctrl.op == SBC) ? (dataWidth + 1)'(wb.carryIn) : '0);
				fl.c = wide[dataWidth];               // Borrow
				fl.v = (opA[msb] != opB[msb]) && (wide[msb] != opA[msb]);
			end
			AND, BIT: wide = {1'b0, opA & opB};
			OR:       wide = {1'b0, opA | opB};
			XOR:      wide = {1'b0, opA ^ opB};
			NOT:      wide = {1'b0, ~opB};         // B only
			SHL: begin
				wide = {1'b0, opA} << shAmt;
				fl.c = wide[dataWidth];               // Last bit out of the top
			end
			SHR: begin
				{wide[msb:0], fl.c} = {opA, 1'b0} >> shAmt;  // Last bit out of the bottom
			end
			default: wide = '0;                    // Undefined, retired as illegal
		endcase

		res  = wide[msb:0];
		fl.z = (res == '0);
		fl.n = res[msb];
	end

	// ========================================================================
	// Write-back record
	// ========================================================================
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			wb.valid <= 1'b0;
		end else if (!wb.stall) begin
			wb.valid <= ctrl.valid;
		end
	end

	always_ff @(posedge CLK) begin
		if (!wb.stall) begin
			wb.data      <= res;
			wb.dest      <= ctrl.addrA;
			wb.flags     <= fl;
			wb.illegal   <= ctrl.illegal;
			wb.writeEn   <= (ctrl.regSeq != READ_ONLY) && !ctrl.illegal;
			wb.flagsLoad <= ctrl.ccLoad && !ctrl.illegal;  // No side effects if illegal
		end
	end

endmodule

`default_nettype wire

/* hw/aluGroupDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module aluGroupDecoder
	import cpuIsaPkg::*;
	import aluCtrlPkg::*;
#(
	parameter int instrDepth = 4
) (
	input  wire                   CLK,
	input  wire                   rstN,
	input  wire                   instrValid,
	input  wire  [instrWidth-1:0] instr,
	output logic                  instrCreditRet,
	aluCtrlIf.decode              ctrl
);

	localparam int ptrW = (instrDepth > 1) ? $clog2(instrDepth) : 1;
	localparam int cntW = $clog2(instrDepth + 1);

	// ========================================================================
	// Instruction buffer, sized by the producer credits
	// ========================================================================
	logic [instrWidth-1:0] buffer [instrDepth];    // Word storage
	logic [ptrW-1:0]       wrPtr;
	logic [ptrW-1:0]       rdPtr;
	logic [cntW-1:0]       count;                  // Words held
	logic                  loadDec;                // Decode register free
	logic                  pop;

	logic [instrWidth-1:0] head;
	aluOpE                 decOp;
	argModeE               decMode;
	logic                  decIllegal;

	assign loadDec = !ctrl.valid || !ctrl.stall;   // Empty or handing off
	assign pop     = (count != '0) && loadDec;

	always_ff @(posedge CLK) begin
		if (instrValid) begin
			buffer[wrPtr] <= instr;                // Credits rule out overflow
		end
	end

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			wrPtr          <= '0;
			rdPtr          <= '0;
			count          <= '0;
			instrCreditRet <= 1'b0;
		end else begin
			if (instrValid) begin
				wrPtr <= (wrPtr == ptrW'(instrDepth - 1)) ? '0 : wrPtr + 1'b1;
			end
			if (pop) begin
				rdPtr <= (rdPtr == ptrW'(instrDepth - 1)) ? '0 : rdPtr + 1'b1;
			end
			count          <= count + cntW'(instrValid) - cntW'(pop);
			instrCreditRet <= pop;                 // One pulse per drained word
		end
	end

	// ========================================================================
	// Field decode of the buffer head
	// ========================================================================
	always_comb begin
		head       = buffer[rdPtr];
		decOp      = aluOpE'(head[opHi:opLo]);
		decMode    = argModeE'(head[modeHi:modeLo]);
		decIllegal = (head[grpHi:grpLo] != groupAlu)  // Not group 3
		          || (head[opHi:opLo] > BIT);          // Codes 13..15
	end

	// Decode register valid
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			ctrl.valid <= 1'b0;
		end else if (loadDec) begin
			ctrl.valid <= pop;
		end
	end

	// Decode register payload
	always_ff @(posedge CLK) begin
		if (pop) begin
			ctrl.op      <= decOp;
			ctrl.illegal <= decIllegal;
			ctrl.ccLoad  <= (decOp != MOV);        // MOV leaves flags alone
			ctrl.addrB   <= head[rbHi:rbLo];
			ctrl.imm     <= head[immWidth-1:0];    // Execute narrows for U4

			case (decOp)
				CMP, BIT: ctrl.regSeq <= READ_ONLY;
				MOV:      ctrl.regSeq <= LOAD_A;
				default:  ctrl.regSeq <= UPDATE_A;
			endcase

			case (decMode)
				REG_REG: begin
					ctrl.addrA <= head[raHi:raLo];
					ctrl.srcB  <= REG_B;
				end
				REG_U4: begin
					ctrl.addrA <= head[raHi:raLo];
					ctrl.srcB  <= IMM4;                // Value sits in the B field
				end
				ACC_U8: begin
					ctrl.addrA <= accReg;              // Byte overlays the A field
					ctrl.srcB  <= IMM8U;
				end
				default: begin
					ctrl.addrA <= accReg;
					ctrl.srcB  <= IMM8S;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* hw/aluResult.sv */
`timescale 1ns/1ps
`default_nettype none

module aluResult
	import cpuIsaPkg::*;
	import aluCtrlPkg::*;
#(
	parameter int dataWidth  = 16,
	parameter int resCredits = 2
) (
	input  wire                   CLK,
	input  wire                   rstN,
	wbIf.result                   wb,
	input  wire                   resCreditRet,
	output logic                  resValid,
	output logic [dataWidth-1:0]  resData,
	output flagsT                 resFlags,
	output logic [regAddrW-1:0]   resDest,
	output logic                  resWrote,
	output logic                  resIllegal
);

	localparam int crW = $clog2(resCredits + 1);

	logic [dataWidth-1:0] regs [numRegs];        // Register file
	flagsT                ccReg;                 // Condition register
	logic [crW-1:0]       credits;               // Consumer slots left
	logic                 retire;
	logic                 fwdA;
	logic                 fwdB;

	// ========================================================================
	// Read ports with bypass from the pending record
	// ========================================================================
	assign fwdA = wb.valid && wb.writeEn && (wb.dest == wb.rdAddrA);
	assign fwdB = wb.valid && wb.writeEn && (wb.dest == wb.rdAddrB);

	assign wb.rdDataA = fwdA ? wb.data : regs[wb.rdAddrA];
	assign wb.rdDataB = fwdB ? wb.data : regs[wb.rdAddrB];
	assign wb.carryIn = (wb.valid && wb.flagsLoad) ? wb.flags.c : ccReg.c;

	// ========================================================================
	// Result credits
	// ========================================================================
	assign retire   = wb.valid && (credits != '0);
	assign wb.stall = wb.valid && (credits == '0);   // Record waits for a slot
	assign resFlags = ccReg;                          // Post-commit flags

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			credits    <= crW'(resCredits);
			ccReg      <= '0;
			resValid   <= 1'b0;
			resWrote   <= 1'b0;
			resIllegal <= 1'b0;
			for (int i = 0; i < numRegs; i++) begin
				regs[i] <= '0;
			end
		end else begin
			credits  <= credits - crW'(retire) + crW'(resCreditRet);
			resValid <= retire;                  // One cycle per result
			if (retire) begin
				resWrote   <= wb.writeEn;
				resIllegal <= wb.illegal;
				if (wb.writeEn) begin
					regs[wb.dest] <= wb.data;        // Commit with the result ports
				end
				if (wb.flagsLoad) begin
					ccReg <= wb.flags;
				end
			end
		end
	end

	// Result payload
	always_ff @(posedge CLK) begin
		if (retire) begin
			resData <= wb.data;
			resDest <= wb.dest;
		end
	end

endmodule

`default_nettype wire

/* hw/aluSubsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module aluSubsystem
	import cpuIsaPkg::*;
	import aluCtrlPkg::*;
#(
	parameter int dataWidth  = 16,
	parameter int instrDepth = 4,
	parameter int resCredits = 2
) (
	input  wire                   CLK,
	input  wire                   rstN,
	// Instruction side
	input  wire                   instrValid,
	input  wire  [instrWidth-1:0] instr,
	output logic                  instrCreditRet,
	// Result side
	output logic                  resValid,
	output logic [dataWidth-1:0]  resData,
	output flagsT                 resFlags,
	output logic [regAddrW-1:0]   resDest,
	output logic                  resWrote,
	output logic                  resIllegal,
	input  wire                   resCreditRet
);

	// ========================================================================
	// Stage links
	// ========================================================================
	aluCtrlIf ctrlBus ();                                  // Decode to execute
	wbIf #(.dataWidth(dataWidth)) wbBus ();                // Execute to result

	aluGroupDecoder #(.instrDepth(instrDepth)) i_aluGroupDecoder (
		.CLK            (CLK),
		.rstN           (rstN),
		.instrValid     (instrValid),
		.instr          (instr),
		.instrCreditRet (instrCreditRet),
		.ctrl           (ctrlBus)
	);

	aluExecute #(.dataWidth(dataWidth)) i_aluExecute (
		.CLK  (CLK),
		.rstN (rstN),
		.ctrl (ctrlBus),
		.wb   (wbBus)
	);

	aluResult #(
		.dataWidth  (dataWidth),
		.resCredits (resCredits)
	) i_aluResult (
		.CLK          (CLK),
		.rstN         (rstN),
		.wb           (wbBus),
		.resCreditRet (resCreditRet),
		.resValid     (resValid),
		.resData      (resData),
		.resFlags     (resFlags),
		.resDest      (resDest),
		.resWrote     (resWrote),
		.resIllegal   (resIllegal)
	);

endmodule

`default_nettype wire

/* hw/cpuIsaPkg.sv */
`default_nettype none

package cpuIsaPkg;

	// ========================================================================
	// Word format and register file geometry
	// ========================================================================
	localparam int instrWidth = 16;                 // Instruction word bits
	localparam int numRegs    = 16;                 // General purpose registers
	localparam int regAddrW   = $clog2(numRegs);    // Register index bits

	localparam int grpHi  = 15;                     // Group field
	localparam int grpLo  = 14;
	localparam int opHi   = 13;                     // ALU operation field
	localparam int opLo   = 10;
	localparam int modeHi = 9;                      // Argument mode field
	localparam int modeLo = 8;
	localparam int raHi   = 7;                      // Register A field
	localparam int raLo   = 4;
	localparam int rbHi   = 3;                      // Register B field
	localparam int rbLo   = 0;

	localparam int immWidth  = 8;                   // Accumulator immediate, bits 7..0
	localparam int imm4Width = 4;                   // Short immediate in the B field

	localparam logic [1:0] groupAlu = 2'd3;         // Top bits 11 select the ALU group
	localparam logic [regAddrW-1:0] accReg = '0;    // Fixed accumulator is R0

	// ========================================================================
	// Operation codes and argument modes
	// ========================================================================
	typedef enum logic [3:0] {
		MOV = 4'd0,  ADD = 4'd1,  ADC = 4'd2,  SUB = 4'd3,
		SBC = 4'd4,  AND = 4'd5,  OR  = 4'd6,  XOR = 4'd7,
		NOT = 4'd8,  SHL = 4'd9,  SHR = 4'd10, CMP = 4'd11,
		BIT = 4'd12                             // 13..15 undefined
	} aluOpE;

	typedef enum logic [1:0] {
		REG_REG = 2'd0,                         // Ra, Rb
		REG_U4  = 2'd1,                         // Ra, unsigned 4-bit
		ACC_U8  = 2'd2,                         // Acc, unsigned 8-bit
		ACC_S8  = 2'd3                          // Acc, sign-extended 8-bit
	} argModeE;

endpackage

`default_nettype wire

/* hw/wbIf.sv */
`timescale 1ns/1ps
`default_nettype none

interface wbIf
	import cpuIsaPkg::*;
	import aluCtrlPkg::*;
#(
	parameter int dataWidth = 16
) ();

	// Register read ports, bypassed in result
	logic [regAddrW-1:0]  rdAddrA;
	logic [regAddrW-1:0]  rdAddrB;
	logic [dataWidth-1:0] rdDataA;
	logic [dataWidth-1:0] rdDataB;
	logic                 carryIn;              // C with pending flags bypassed

	// Write-back record
	logic                 valid;
	logic [dataWidth-1:0] data;
	logic [regAddrW-1:0]  dest;
	logic                 writeEn;
	flagsT                flags;
	logic                 flagsLoad;
	logic                 illegal;
	logic                 stall;                // No result credit left

	modport execute (output rdAddrA, rdAddrB, valid, data, dest, writeEn, flags,
	                        flagsLoad, illegal,
	                 input  rdDataA, rdDataB, carryIn, stall);
	modport result  (input  rdAddrA, rdAddrB, valid, data, dest, writeEn, flags,
	                        flagsLoad, illegal,
	                 output rdDataA, rdDataB, carryIn, stall);

endinterface

`default_nettype wire

/* sim.f */
hw/cpuIsaPkg.sv
hw/aluCtrlPkg.sv
hw/aluCtrlIf.sv
hw/wbIf.sv
hw/aluGroupDecoder.sv
hw/aluExecute.sv
hw/aluResult.sv
hw/aluSubsystem.sv
verif/aluSubsystem_assert.sv
verif/aluSubsystemTb.sv

/* verif/aluSubsystemTb.sv */
`timescale 1ns/1ps
`default_nettype none

module aluSubsystemTb
	import cpuIsaPkg::*;
	import aluCtrlPkg::*;
();

	localparam int dataWidth   = 16;
	localparam int instrDepth  = 4;
	localparam int resCredits  = 2;
	localparam int numRows     = 25;
	localparam int clkPeriod   = 4;                     // ns
	localparam int resetCycles = 8;
	localparam int timeoutNs   = (numRows * 20 + resetCycles) * clkPeriod;

	typedef struct packed {
		logic [instrWidth-1:0] word;
		logic [dataWidth-1:0]  data;                    // Ignored on illegal rows
		logic [3:0]            flags;                   // z n c v
		logic [3:0]            dest;
		logic                  wrote;
		logic                  illegal;
	} rowT;

	logic                  CLK = 1'b0;
	logic                  rstN;
	logic                  instrValid;
	logic [instrWidth-1:0] instr;
	logic                  instrCreditRet;
	logic                  resValid;
	logic [dataWidth-1:0]  resData;
	flagsT                 resFlags;
	logic [regAddrW-1:0]   resDest;
	logic                  resWrote;
	logic                  resIllegal;
	logic                  resCreditRet;

	rowT    rows [numRows];
	int     fillIdx;
	int     sendIdx;                                   // Next row to issue
	int     resIdx;                                    // Next row expected back
	int     prodCredits;
	int     cycle;
	int     delay;
	int     errors;
	int     rowsPassed;
	int     rowsFailed;
	int     dueQ [$];                                  // Cycles when a credit goes back
	integer seed;

	aluSubsystem #(
		.dataWidth  (dataWidth),
		.instrDepth (instrDepth),
		.resCredits (resCredits)
	) i_aluSubsystem (
		.CLK            (CLK),
		.rstN           (rstN),
		.instrValid     (instrValid),
		.instr          (instr),
		.instrCreditRet (instrCreditRet),
		.resValid       (resValid),
		.resData        (resData),
		.resFlags       (resFlags),
		.resDest        (resDest),
		.resWrote       (resWrote),
		.resIllegal     (resIllegal),
		.resCreditRet   (resCreditRet)
	);

	always #(clkPeriod / 2) CLK = ~CLK;

	// ========================================================================
	// Word building and the expected-value table
	// ========================================================================
	function automatic logic [instrWidth-1:0] regWord(input aluOpE op, input argModeE mode,
	                                                   input logic [3:0] ra, input logic [3:0] rb);
		return {groupAlu, op, mode, ra, rb};
	endfunction

	function automatic logic [instrWidth-1:0] accWord(input aluOpE op, input argModeE mode,
	                                                   input logic [7:0] imm);
		return {groupAlu, op, mode, imm};              // Byte overlays both register fields
	endfunction

	task automatic addRow(input logic [15:0] word, input logic [15:0] data,
	                      input logic [3:0] flags, input logic [3:0] dest,
	                      input logic wrote, input logic illegal);
		rows[fillIdx] = {word, data, flags, dest, wrote, illegal};
		fillIdx++;
	endtask

	task automatic fillRows();
		addRow(regWord(MOV, REG_U4, 1, 5),    16'h0005, 4'b0000, 1, 1, 0);  // R1 = 5
		addRow(accWord(MOV, ACC_U8, 8'h34),   16'h0034, 4'b0000, 0, 1, 0);
		addRow(accWord(MOV, ACC_S8, 8'h80),   16'hFF80, 4'b0000, 0, 1, 0);  // Sign extended
		addRow(regWord(MOV, REG_REG, 2, 1),   16'h0005, 4'b0000, 2, 1, 0);
		addRow(regWord(ADD, REG_REG, 2, 1),   16'h000A, 4'b0000, 2, 1, 0);
		addRow(accWord(ADD, ACC_U8, 8'h80),   16'h0000, 4'b1010, 0, 1, 0);  // Z and carry out
		addRow(regWord(ADC, REG_U4, 1, 3),    16'h0009, 4'b0000, 1, 1, 0);  // 5 + 3 + C
		addRow(regWord(SUB, REG_U4, 1, 10),   16'hFFFF, 4'b0110, 1, 1, 0);  // Borrow
		addRow(regWord(SBC, REG_U4, 2, 0),    16'h0009, 4'b0000, 2, 1, 0);  // 10 - 0 - C
		addRow(regWord(MOV, REG_U4, 3, 1),    16'h0001, 4'b0000, 3, 1, 0);
		addRow(regWord(SHL, REG_U4, 3, 15),   16'h8000, 4'b0100, 3, 1, 0);
		addRow(regWord(SUB, REG_U4, 3, 1),    16'h7FFF, 4'b0001, 3, 1, 0);  // Signed overflow
		addRow(regWord(MOV, REG_U4, 4, 7),    16'h0007, 4'b0001, 4, 1, 0);  // V kept by MOV
		addRow(regWord(CMP, REG_U4, 4, 7),    16'h0000, 4'b1000, 4, 0, 0);
		addRow(regWord(BIT, REG_U4, 1, 8),    16'h0008, 4'b0000, 1, 0, 0);
		addRow(regWord(CMP, REG_REG, 3, 1),   16'h8000, 4'b0111, 3, 0, 0);  // 7FFF - FFFF
		addRow(regWord(ADD, REG_U4, 4, 0),    16'h0007, 4'b0000, 4, 1, 0);  // R4 untouched
		addRow(regWord(XOR, REG_REG, 1, 3),   16'h8000, 4'b0100, 1, 1, 0);  // R1, R3 untouched
		addRow(16'h4512,                      16'h0000, 4'b0100, 0, 0, 1);  // Group 1 ADD
		addRow(16'hF812,                      16'h0000, 4'b0100, 0, 0, 1);  // Op code 14
		addRow(regWord(NOT, REG_REG, 5, 1),   16'h7FFF, 4'b0000, 5, 1, 0);  // R1 still 8000
		addRow(regWord(SHR, REG_U4, 5, 3),    16'h0FFF, 4'b0010, 5, 1, 0);  // Bit 2 shifted out
		addRow(regWord(AND, REG_REG, 5, 3),   16'h0FFF, 4'b0000, 5, 1, 0);  // C cleared
		addRow(accWord(ADD, ACC_S8, 8'hFF),   16'hFFFF, 4'b0100, 0, 1, 0);
		addRow(accWord(SUB, ACC_S8, 8'h80),   16'h007F, 4'b0000, 0, 1, 0);  // FFFF - FF80
	endtask

	// ========================================================================
	// Result checks
	// ========================================================================
	task automatic checkValue(input string name, input logic [15:0] expected,
	                          input logic [15:0] actual, inout bit rowOk);
		assert (actual === expected) else begin
			$display("CHECK FAILED at %0t ns: %s expected 0x%h, actual 0x%h",
			         $time, name, expected, actual);
			errors++;
			rowOk = 1'b0;
		end
	endtask

	task automatic checkRow(input int idx);
		bit rowOk;
		rowOk = 1'b1;
		if (!rows[idx].illegal) begin                   // Payload meaningless when illegal
			checkValue("resData", rows[idx].data, resData, rowOk);
			checkValue("resDest", {12'h0, rows[idx].dest}, {12'h0, resDest}, rowOk);
		end
		checkValue("resFlags", {12'h0, rows[idx].flags}, {12'h0, resFlags}, rowOk);
		checkValue("resWrote", {15'h0, rows[idx].wrote}, {15'h0, resWrote}, rowOk);
		checkValue("resIllegal", {15'h0, rows[idx].illegal}, {15'h0, resIllegal}, rowOk);
		if (rowOk) begin
			rowsPassed++;
			$display("row %2d  word %h  ok", idx, rows[idx].word);
		end else begin
			rowsFailed++;
			$display("row %2d  word %h  mismatch", idx, rows[idx].word);
		end
	endtask

	// ========================================================================
	// Producer and consumer, both on the falling edge
	// ========================================================================
	always @(negedge CLK) begin
		if (!rstN) begin
			assert (!instrCreditRet && !resValid) else begin
				$display("Credit return or result seen while reset is asserted at %0t ns", $time);
				errors++;
			end
		end else begin
			cycle++;
			if (instrCreditRet) begin
				prodCredits++;                          // One word drained
			end
			assert (prodCredits <= instrDepth) else begin
				$display("More instruction credits returned than words sent at %0t ns", $time);
				errors++;
			end
			if (sendIdx < numRows && prodCredits > 0) begin
				instrValid <= 1'b1;
				instr      <= rows[sendIdx].word;
				prodCredits--;
				sendIdx++;
			end else begin
				instrValid <= 1'b0;
			end

			if (resValid) begin
				if (resIdx < numRows) begin
					checkRow(resIdx);
					resIdx++;
				end else begin
					$display("Extra result beyond the last table row at %0t ns", $time);
					errors++;
				end
				delay = $unsigned($random(seed)) % 6;  // 0 to 5 cycles
				dueQ.push_back(cycle + delay);
			end
			if (dueQ.size() > 0 && dueQ[0] <= cycle) begin
				void'(dueQ.pop_front());
				resCreditRet <= 1'b1;                   // One slot per pulse
			end else begin
				resCreditRet <= 1'b0;
			end
		end
	end

	initial begin
		#(timeoutNs);
		$display("Timeout with %0d of %0d results received", resIdx, numRows);
		$display("TB FAILED");
		$finish;
	end

	initial begin
		seed         = 32'h6190_29c3;
		rstN         = 1'b0;
		instrValid   = 1'b0;
		instr        = '0;
		resCreditRet = 1'b0;
		prodCredits  = instrDepth;                     // Full buffer owned at start
		fillRows();

		repeat (resetCycles) @(negedge CLK);
		rstN <= 1'b1;

		wait (resIdx == numRows);
		repeat (10) @(negedge CLK);                    // Catch stray results and credits
		assert (prodCredits == instrDepth) else begin
			$display("Credits not all back at the end: producer holds %0d", prodCredits);
			errors++;
		end
		if (i_aluSubsystem.i_aluSubsystemAssert.failCount != 0) begin
			$display("Bound protocol assertions failed %0d times",
			         i_aluSubsystem.i_aluSubsystemAssert.failCount);
			errors += i_aluSubsystem.i_aluSubsystemAssert.failCount;
		end

		$display("Rows %0d, passed %0d, failed %0d, errors %0d",
		         numRows, rowsPassed, rowsFailed, errors);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verif/aluSubsystem_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module aluSubsystemAssert #(
	parameter int instrDepth = 4,
	parameter int resCredits = 2
) (
	input wire CLK,
	input wire rstN,
	input wire instrValid,
	input wire instrCreditRet,
	input wire resValid,
	input wire resWrote,
	input wire resIllegal,
	input wire resCreditRet
);

	int unsigned resOut;                               // Results not yet credited back
	int unsigned accWords;                             // Words taken in
	int unsigned retWords;                             // Instruction credits returned
	int unsigned failCount;                            // Property failures so far

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			resOut   <= 0;
			accWords <= 0;
			retWords <= 0;
		end else begin
			resOut   <= resOut + 32'(resValid) - 32'(resCreditRet);
			accWords <= accWords + 32'(instrValid);
			retWords <= retWords + 32'(instrCreditRet);
		end
	end

	// ========================================================================
	// Port protocol
	// ========================================================================
	noResInReset: assert property (@(posedge CLK) !rstN |-> !resValid)
		else begin
			failCount++;
			$error("resValid high during reset");
		end

	wroteNotIllegal: assert property (@(posedge CLK) disable iff (!rstN)
		!(resWrote && resIllegal))
		else begin
			failCount++;
			$error("resWrote and resIllegal high together");
		end

	resCreditBound: assert property (@(posedge CLK) disable iff (!rstN)
		resOut <= resCredits)
		else begin
			failCount++;
			$error("more results outstanding than consumer slots");
		end

	instrCreditBound: assert property (@(posedge CLK) disable iff (!rstN)
		retWords <= accWords)
		else begin
			failCount++;
			$error("instruction credits returned exceed accepted words");
		end

	bufferBound: assert property (@(posedge CLK) disable iff (!rstN)
		accWords - retWords <= instrDepth)
		else begin
			failCount++;
			$error("instruction buffer holds more than its depth");
		end

endmodule

bind aluSubsystem aluSubsystemAssert #(
	.instrDepth (instrDepth),
	.resCredits (resCredits)
) i_aluSubsystemAssert (
	.CLK            (CLK),
	.rstN           (rstN),
	.instrValid     (instrValid),
	.instrCreditRet (instrCreditRet),
	.resValid       (resValid),
	.resWrote       (resWrote),
	.resIllegal     (resIllegal),
	.resCreditRet   (resCreditRet)
);

`default_nettype wire
